//--- exec_macros.svh
// global sizing for the execute slice: data width, register count and index width
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// width of one data word and of the register bank entries
`define XLEN 32

// architectural registers, x0 included
`define NREGS 32

// bits needed to index one register
`define REG_AW 5

`endif

//--- rv_isa_pkg.sv
// RV32I instruction encodings for the OP, OP-IMM and LUI groups handled by the slice
package rv_isa_pkg;

    // major opcodes, bits [6:0] of the instruction word
    typedef enum logic [6:0] {
        OP     = 7'b0110011,  // register-register ALU group
        OP_IMM = 7'b0010011,  // register-immediate ALU group
        LUI    = 7'b0110111   // load upper immediate
    } opcode_e;

    // funct3 field, bits [14:12]
    // the same codes serve OP and OP-IMM, only the funct7 handling differs
    localparam logic [2:0] F3_ADD_SUB = 3'b000;  // add, sub, addi
    localparam logic [2:0] F3_SLL     = 3'b001;  // sll, slli
    localparam logic [2:0] F3_SLT     = 3'b010;  // slt, slti
    localparam logic [2:0] F3_SLTU    = 3'b011;  // sltu, sltiu
    localparam logic [2:0] F3_XOR     = 3'b100;  // xor, xori
    localparam logic [2:0] F3_SRL_SRA = 3'b101;  // srl, sra, srli, srai
    localparam logic [2:0] F3_OR      = 3'b110;  // or, ori
    localparam logic [2:0] F3_AND     = 3'b111;  // and, andi

    // funct7 field, bits [31:25]
    localparam logic [6:0] F7_BASE = 7'b0000000;  // plain form of the operation
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // bit 30 set turns add into sub and srl into sra

endpackage

//--- exec_pkg.sv
// shared types of the execute datapath: data word, register index and ALU operation
package exec_pkg;

    `include "exec_macros.svh"

    // one data word as it travels between register bank and ALU
    typedef logic [`XLEN-1:0] word_t;

    // register index, wide enough for all NREGS entries
    typedef logic [`REG_AW-1:0] reg_idx_t;

    // operation codes the decoder hands to the ALU stage
    // the encoding is internal, it does not follow funct3
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,   // signed less than gives 1 or 0
        ALU_SLTU   = 4'd4,   // unsigned less than gives 1 or 0
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10   // operand b straight through, used by lui
    } alu_op_e;

endpackage

//--- decode_if.sv
// decoded control bundle from the instruction decoder to the execute datapath
`timescale 1ns/100ps

interface decode_if;
    import exec_pkg::*;

    reg_idx_t rs1;      // first source register
    reg_idx_t rs2;      // second source register, ignored when use_imm is set
    reg_idx_t rd;       // destination register
    word_t    imm;      // sign-extended I-type or U-type immediate
    logic     use_imm;  // operand b comes from imm instead of rs2
    alu_op_e  alu_op;   // what the ALU computes
    logic     issue;    // one-cycle strobe for a legal, valid instruction

    // decoder side drives every field
    modport ctrl (
        output rs1, rs2, rd, imm, use_imm, alu_op, issue
    );

    // datapath side only samples
    modport dp (
        input rs1, rs2, rd, imm, use_imm, alu_op, issue
    );

endinterface

//--- instr_decoder.sv
// combinational RV32I decoder for the OP, OP-IMM and LUI groups, flags everything else
`timescale 1ns/100ps

module instr_decoder (
    input  logic            instr_valid_i,
    input  exec_pkg::word_t instr_i,
    output logic            illegal_o,
    decode_if.ctrl          dec
);
    import exec_pkg::*;
    import rv_isa_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i_type;
    word_t      imm_u_type;
    logic       alt;      // funct7 carries the alternate pattern
    logic       sub_sel;  // only the OP group may turn add into sub
    alu_op_e    f3_op;    // operation picked by funct3 alone
    logic       legal;

    // fixed instruction fields
    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};  // sign extended 12-bit value
    assign imm_u_type = {instr_i[31:12], 12'h000};             // upper 20 bits, low part zero

    assign alt     = (funct7 == F7_ALT);
    assign sub_sel = alt && (opcode == OP);  // in addi bit 30 is just immediate data

    // register indices go out unconditionally, the datapath ignores them without issue
    assign dec.rs1 = instr_i[19:15];
    assign dec.rs2 = instr_i[24:20];
    assign dec.rd  = instr_i[11:7];

    // funct3 selects the operation family, alt chooses the variant where one exists
    always_comb begin
        f3_op = ALU_ADD;
        case (funct3)
            F3_ADD_SUB: f3_op = sub_sel ? ALU_SUB : ALU_ADD;
            F3_SLL:     f3_op = ALU_SLL;
            F3_SLT:     f3_op = ALU_SLT;
            F3_SLTU:    f3_op = ALU_SLTU;
            F3_XOR:     f3_op = ALU_XOR;
            F3_SRL_SRA: f3_op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      f3_op = ALU_OR;
            F3_AND:     f3_op = ALU_AND;
        endcase
    end

    // group specific legality, operand select and immediate choice
    always_comb begin
        legal       = 1'b0;
        dec.use_imm = 1'b0;
        dec.imm     = imm_i_type;
        dec.alu_op  = f3_op;
        case (opcode)
            OP: begin
                // alternate funct7 is only defined for sub and sra
                legal = (funct7 == F7_BASE) ||
                        (alt && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
            end
            OP_IMM: begin
                dec.use_imm = 1'b1;
                if (funct3 == F3_SLL) begin
                    legal = (funct7 == F7_BASE);            // slli has no alternate form
                end else if (funct3 == F3_SRL_SRA) begin
                    legal = (funct7 == F7_BASE) || alt;     // srli or srai
                end else begin
                    legal = 1'b1;                           // upper bits belong to the immediate
                end
            end
            LUI: begin
                legal       = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm     = imm_u_type;
                dec.alu_op  = ALU_PASS_B;  // result is the immediate itself
            end
            default: legal = 1'b0;
        endcase
    end

    assign dec.issue = instr_valid_i && legal;   // only legal work reaches the ALU stage
    assign illegal_o = instr_valid_i && !legal;  // same-cycle flag, nothing gets written

endmodule

//--- regbank.sv
// 32 by 32 register bank with two combinational read ports, one write port and x0 fixed at zero
`timescale 1ns/100ps
`include "exec_macros.svh"

module regbank (
    input  logic               clk,
    input  logic               reset,
    input  exec_pkg::reg_idx_t rs1_i,
    input  exec_pkg::reg_idx_t rs2_i,
    input  exec_pkg::reg_idx_t rd_i,
    input  logic               we_i,
    input  exec_pkg::word_t    wdata_i,
    output exec_pkg::word_t    rdata1_o,
    output exec_pkg::word_t    rdata2_o
);
    import exec_pkg::*;

    word_t regs [`NREGS];
    logic  hit1;  // port 1 reads the entry that is being written this cycle
    logic  hit2;  // same for port 2

    // all entries clear on reset, x0 is never written afterwards
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= wdata_i;
        end
    end

    assign hit1 = we_i && (rd_i == rs1_i);
    assign hit2 = we_i && (rd_i == rs2_i);

    // x0 reads zero even while a write to it is pending
    // a pending write is passed through so the following instruction sees it at once
    assign rdata1_o = (rs1_i == '0) ? '0 : (hit1 ? wdata_i : regs[rs1_i]);
    assign rdata2_o = (rs2_i == '0) ? '0 : (hit2 ? wdata_i : regs[rs2_i]);

endmodule

//--- alu_stage.sv
// ALU stage: picks operand b, computes the operation and registers result, destination and valid
`timescale 1ns/100ps

module alu_stage (
    input  logic               clk,
    input  logic               reset,
    decode_if.dp               dec,
    input  exec_pkg::word_t    rs1_data_i,
    input  exec_pkg::word_t    rs2_data_i,
    output exec_pkg::word_t    result_o,
    output exec_pkg::reg_idx_t rd_o,
    output logic               result_valid_o
);
    import exec_pkg::*;

    word_t      op_b;
    logic [4:0] shamt;    // RV32 shifts only look at the low five bits
    word_t      alu_res;

    assign op_b  = dec.use_imm ? dec.imm : rs2_data_i;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:    alu_res = rs1_data_i + op_b;
            ALU_SUB:    alu_res = rs1_data_i - op_b;
            ALU_SLL:    alu_res = rs1_data_i << shamt;
            ALU_SLT:    alu_res = word_t'($signed(rs1_data_i) < $signed(op_b));  // zero extended flag
            ALU_SLTU:   alu_res = word_t'(rs1_data_i < op_b);
            ALU_XOR:    alu_res = rs1_data_i ^ op_b;
            ALU_SRL:    alu_res = rs1_data_i >> shamt;
            ALU_SRA:    alu_res = word_t'($signed(rs1_data_i) >>> shamt);      // sign bit fills in
            ALU_OR:     alu_res = rs1_data_i | op_b;
            ALU_AND:    alu_res = rs1_data_i & op_b;
            ALU_PASS_B: alu_res = op_b;                                         // lui
            default:    alu_res = '0;
        endcase
    end

    // result register, which also feeds the register bank write port
    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid_o <= 1'b0;
            result_o       <= '0;
            rd_o           <= '0;
        end else begin
            result_valid_o <= dec.issue;  // one cycle after issue, low for gaps and illegal words
            if (dec.issue) begin
                result_o <= alu_res;
                rd_o     <= dec.rd;
            end
        end
    end

endmodule

//--- exec_core.sv
// execute slice top level joining the decoder, register bank and ALU stage
`timescale 1ns/100ps

module exec_core (
    input  logic               clk,
    input  logic               reset,
    input  logic               instr_valid_i,
    input  exec_pkg::word_t    instr_i,
    output logic               result_valid_o,
    output exec_pkg::word_t    result_o,
    output exec_pkg::reg_idx_t rd_o,
    output logic               illegal_o
);
    import exec_pkg::*;

    word_t rs1_data;  // operand from the first read port
    word_t rs2_data;  // operand from the second read port

    decode_if dec_bus ();

    instr_decoder i_instr_decoder (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .illegal_o     (illegal_o),
        .dec           (dec_bus.ctrl)
    );

    // write side runs from the registered ALU outputs
    regbank i_regbank (
        .clk      (clk),
        .reset    (reset),
        .rs1_i    (dec_bus.rs1),
        .rs2_i    (dec_bus.rs2),
        .rd_i     (rd_o),
        .we_i     (result_valid_o),
        .wdata_i  (result_o),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    alu_stage i_alu_stage (
        .clk            (clk),
        .reset          (reset),
        .dec            (dec_bus.dp),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .result_o       (result_o),
        .rd_o           (rd_o),
        .result_valid_o (result_valid_o)
    );

endmodule

//--- tb_exec_core.sv
// self-checking testbench for the execute slice with a stimulus table and a random stream
`timescale 1ns/100ps

module tb_exec_core;

    localparam logic [6:0] OPC_OP   = 7'h33;  // register-register group
    localparam logic [6:0] OPC_IMM  = 7'h13;  // register-immediate group
    localparam logic [6:0] OPC_LUI  = 7'h37;
    localparam logic [6:0] OPC_LOAD = 7'h03;  // not supported, must be flagged
    localparam int         N_RANDOM = 200;

    logic        clk = 1'b0;
    logic        reset;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic        result_valid_o;
    logic [31:0] result_o;
    logic [4:0]  rd_o;
    logic        illegal_o;

    logic [31:0] shadow [32];            // architectural state as the ISA defines it
    logic [31:0] tbl_instr [$];
    logic [31:0] tbl_exp [$];
    bit          tbl_legal [$];
    logic        exp_valid = 1'b0;       // what the outputs should show after the next edge
    logic [31:0] exp_result = '0;
    logic [4:0]  exp_rd = '0;
    logic [31:0] lfsr = 32'hebf3c2be;
    int          mismatch_cnt = 0;
    int          fail_cnt = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;

    exec_core i_exec_core (
        .clk            (clk),
        .reset          (reset),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .rd_o           (rd_o),
        .illegal_o      (illegal_o)
    );

    always #2 clk = ~clk;  // 4 ns period

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    // ISA reference, reads the shadow registers before the instruction retires
    function automatic logic [31:0] model_result(input logic [31:0] instr, output bit legal);
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        logic [6:0]  f7;
        f3    = instr[14:12];
        f7    = instr[31:25];
        a     = shadow[instr[19:15]];
        b     = (instr[6:0] == OPC_OP) ? shadow[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
        legal = 1'b1;
        if (instr[6:0] == OPC_LUI) return {instr[31:12], 12'h000};
        if (instr[6:0] == OPC_OP)
            legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        else if (instr[6:0] == OPC_IMM && f3 == 3'd1)
            legal = (f7 == 7'h00);  // slli allows no upper bits
        else if (instr[6:0] == OPC_IMM && f3 == 3'd5)
            legal = (f7 == 7'h00) || (f7 == 7'h20);
        else if (instr[6:0] != OPC_IMM)
            legal = 1'b0;
        case (f3)
            3'd0: return (instr[6:0] == OPC_OP && f7[5]) ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (f7[5]) return $signed(a) >>> b[4:0];  // sign bit fills the top
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hb4bcd35c) : (s >> 1);
    endfunction

    // collects n bits, one LFSR step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return val;
    endfunction

    function automatic logic [31:0] build_random_instr();
        logic [1:0]  group;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        group = 2'(take_bits(2));
        rd    = 5'(take_bits(5));
        rs1   = 5'(take_bits(5));
        rs2   = 5'(take_bits(5));
        f3    = 3'(take_bits(3));
        alt   = 1'(take_bits(1));
        imm   = 12'(take_bits(12));
        if (group == 2'd0) return enc_r((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                                        rs2, rs1, f3, rd);
        if (group == 2'd3) return enc_u({imm, 8'(take_bits(8))}, rd);
        if (f3 == 3'd1) imm[11:5] = 7'h00;                    // slli
        if (f3 == 3'd5) imm[11:5] = alt ? 7'h20 : 7'h00;       // srai or srli
        return enc_i(imm, rs1, f3, rd, OPC_IMM);
    endfunction

    task automatic add_entry(input logic [31:0] instr, input logic [31:0] exp, input bit legal);
        tbl_instr.push_back(instr);
        tbl_exp.push_back(exp);
        tbl_legal.push_back(legal);
    endtask

    task automatic print_counts();
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    endtask

    // compares the registered outputs with the instruction issued one cycle earlier
    task automatic check_outputs();
        if (result_valid_o !== exp_valid) begin
            if (exp_valid) $display("at %0t: result_valid_o missing for rd %0d", $time, exp_rd);
            else $display("at %0t: result_valid_o high with no instruction issued", $time);
            fail_cnt++;
        end else if (exp_valid) begin
            if (result_o !== exp_result) begin
                $display("Mismatch at %0t: result_o expected %h, got %h",
                         $time, exp_result, result_o);
                mismatch_cnt++;
            end
            if (rd_o !== exp_rd) begin
                $display("Mismatch at %0t: rd_o expected %0d, got %0d", $time, exp_rd, rd_o);
                mismatch_cnt++;
            end
        end
    endtask

    // one cycle: check the previous result, drive a word on the falling edge, check illegal_o
    task automatic step(input logic valid, input logic [31:0] instr,
                        output logic [31:0] res, output bit legal);
        @(negedge clk);
        check_outputs();
        instr_valid_i = valid;
        instr_i       = instr;
        res           = model_result(instr, legal);
        exp_valid     = valid && legal;
        exp_result    = res;
        exp_rd        = instr[11:7];
        if (exp_valid && instr[11:7] != 5'd0) shadow[instr[11:7]] = res;  // x0 stays zero
        #1;
        if (illegal_o !== (valid && !legal)) begin
            $display("Mismatch at %0t: illegal_o expected %b, got %b",
                     $time, valid && !legal, illegal_o);
            mismatch_cnt++;
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            print_counts();
            $display("test failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] res;
        bit          legal;
        reset         = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        for (int i = 0; i < 32; i++) shadow[i] = '0;
        // immediates read back through x0
        add_entry(enc_i(12'h005, 5'd0, 3'd0, 5'd1, OPC_IMM), 32'h0000_0005, 1);
        add_entry(enc_i(12'hffd, 5'd0, 3'd0, 5'd2, OPC_IMM), 32'hffff_fffd, 1);
        add_entry(enc_i(12'h7ff, 5'd0, 3'd0, 5'd3, OPC_IMM), 32'h0000_07ff, 1);
        add_entry(enc_i(12'h800, 5'd0, 3'd0, 5'd4, OPC_IMM), 32'hffff_f800, 1);
        add_entry(enc_u(20'h80000, 5'd5), 32'h8000_0000, 1);
        // every register-register operation
        add_entry(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd6), 32'h0000_0002, 1);
        add_entry(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd7), 32'h0000_0008, 1);
        add_entry(enc_r(7'h00, 5'd1, 5'd1, 3'd1, 5'd8), 32'h0000_00a0, 1);
        add_entry(enc_r(7'h00, 5'd1, 5'd2, 3'd2, 5'd9), 32'h0000_0001, 1);   // -3 < 5 signed
        add_entry(enc_r(7'h00, 5'd1, 5'd2, 3'd3, 5'd10), 32'h0000_0000, 1);  // not unsigned
        add_entry(enc_r(7'h00, 5'd2, 5'd1, 3'd4, 5'd11), 32'hffff_fff8, 1);
        add_entry(enc_r(7'h00, 5'd1, 5'd5, 3'd5, 5'd12), 32'h0400_0000, 1);
        add_entry(enc_r(7'h20, 5'd1, 5'd5, 3'd5, 5'd13), 32'hfc00_0000, 1);
        add_entry(enc_r(7'h00, 5'd3, 5'd1, 3'd6, 5'd14), 32'h0000_07ff, 1);
        add_entry(enc_r(7'h00, 5'd3, 5'd2, 3'd7, 5'd15), 32'h0000_07fd, 1);
        // immediate forms with negative immediates
        add_entry(enc_i(12'hffe, 5'd2, 3'd2, 5'd16, OPC_IMM), 32'h0000_0001, 1);
        add_entry(enc_i(12'hfff, 5'd1, 3'd3, 5'd17, OPC_IMM), 32'h0000_0001, 1);
        add_entry(enc_i(12'hfff, 5'd1, 3'd4, 5'd18, OPC_IMM), 32'hffff_fffa, 1);
        add_entry(enc_i(12'h0f0, 5'd1, 3'd6, 5'd19, OPC_IMM), 32'h0000_00f5, 1);
        add_entry(enc_i(12'h0ff, 5'd2, 3'd7, 5'd20, OPC_IMM), 32'h0000_00fd, 1);
        add_entry(enc_i(12'h004, 5'd1, 3'd1, 5'd21, OPC_IMM), 32'h0000_0050, 1);
        add_entry(enc_i(12'h004, 5'd5, 3'd5, 5'd22, OPC_IMM), 32'h0800_0000, 1);
        add_entry(enc_i(12'h404, 5'd5, 3'd5, 5'd23, OPC_IMM), 32'hf800_0000, 1);
        // dependent chain on x24, each word reads the result of the one before
        add_entry(enc_i(12'h001, 5'd0, 3'd0, 5'd24, OPC_IMM), 32'h0000_0001, 1);
        add_entry(enc_r(7'h00, 5'd24, 5'd24, 3'd0, 5'd24), 32'h0000_0002, 1);
        add_entry(enc_r(7'h00, 5'd24, 5'd24, 3'd0, 5'd24), 32'h0000_0004, 1);
        add_entry(enc_i(12'h003, 5'd24, 3'd1, 5'd24, OPC_IMM), 32'h0000_0020, 1);
        add_entry(enc_r(7'h20, 5'd1, 5'd24, 3'd0, 5'd25), 32'h0000_001b, 1);
        // x0 shows the result but keeps reading zero
        add_entry(enc_i(12'h07b, 5'd0, 3'd0, 5'd0, OPC_IMM), 32'h0000_007b, 1);
        add_entry(enc_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd26), 32'h0000_0005, 1);
        // unsupported words aimed at x27, then x27 must still be zero
        add_entry(enc_i(12'h000, 5'd1, 3'd2, 5'd27, OPC_LOAD), 32'h0, 0);
        add_entry(enc_r(7'h20, 5'd2, 5'd1, 3'd4, 5'd27), 32'h0, 0);
        add_entry(enc_i(12'h401, 5'd1, 3'd1, 5'd27, OPC_IMM), 32'h0, 0);
        add_entry(enc_i(12'h000, 5'd27, 3'd0, 5'd28, OPC_IMM), 32'h0000_0000, 1);
        add_entry(enc_u(20'h12345, 5'd29), 32'h1234_5000, 1);
        add_entry(enc_i(12'h678, 5'd29, 3'd0, 5'd29, OPC_IMM), 32'h1234_5678, 1);
        cycle_limit = (tbl_instr.size() + N_RANDOM) * 2 + 50;

        repeat (8) @(negedge clk);
        reset = 1'b0;

        for (int k = 0; k < tbl_instr.size(); k++) begin
            step(1'b1, tbl_instr[k], res, legal);
            if (legal != tbl_legal[k] || (legal && res !== tbl_exp[k])) begin
                $display("table entry %0d does not agree with the ISA model", k);
                fail_cnt++;
            end
        end

        for (int n = 0; n < N_RANDOM; n++) begin
            if (2'(take_bits(2)) == 2'b11) step(1'b0, take_bits(32), res, legal);  // idle gap
            step(1'b1, build_random_instr(), res, legal);
        end
        step(1'b0, 32'h0, res, legal);  // drains the last result
        step(1'b0, 32'h0, res, legal);

        print_counts();
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- exec_core.f
+incdir+.
rv_isa_pkg.sv
exec_pkg.sv
decode_if.sv
instr_decoder.sv
regbank.sv
alu_stage.sv
exec_core.sv
tb_exec_core.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_exec_core
RTL_TOP    ?= exec_core
FILELIST   ?= exec_core.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
